// File: src/rvseed_defines.svh
// data width, register count, fetch-queue depth, retire-credit limit and derived widths
`ifndef RVSEED_DEFINES_SVH
`define RVSEED_DEFINES_SVH

// register and datapath width
`define XLEN 64

// integer register file entries, x0 included
`define NREG 32

// fetch-queue entries, equal to the instruction credits granted after reset
`define FQ_DEPTH 4

// most retire credits the core may hold at once
`define RET_CREDIT_MAX 4

`define REG_AW ($clog2(`NREG))                  // register index width
`define FQ_PTR_W ($clog2(`FQ_DEPTH))            // fetch-queue pointer width
`define FQ_CNT_W ($clog2(`FQ_DEPTH + 1))        // fetch-queue occupancy width
`define RET_CNT_W ($clog2(`RET_CREDIT_MAX + 1)) // retire-credit counter width

`endif

// File: src/rvseed_pkg.sv
// instruction word union, major opcode constants and ALU operation enum
package rvseed_pkg;

    // one instruction word, read as R-type or I-type
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_view;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_view;
    } rv_inst_u;

    localparam logic [6:0] OPC_OP     = 7'b0110011; // register-register
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // register-immediate

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT,
        ALU_NONE  // unknown encodings
    } alu_op_e;

endpackage

// File: src/if_stage.sv
// fetch queue with credit return and sequential pc tagging
`timescale 1ns/10ps
`include "rvseed_defines.svh"

module if_stage (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               inst_valid_i,
    input  logic [31:0]        inst_i,
    input  logic               stall_i,
    output logic               inst_credit_o,
    output logic               fq_valid_o,
    output logic [31:0]        fq_inst_o,
    output logic [`XLEN-1:0]   fq_pc_o
);

    logic [31:0]           fq_mem [`FQ_DEPTH];
    logic [`FQ_PTR_W-1:0]  wr_ptr;
    logic [`FQ_PTR_W-1:0]  rd_ptr;
    logic [`FQ_CNT_W-1:0]  fq_cnt;
    logic [`XLEN-1:0]      pc_q;
    logic                  credit_q;
    logic                  deq;

    assign fq_valid_o    = (fq_cnt != '0);
    assign fq_inst_o     = fq_mem[rd_ptr];
    assign fq_pc_o       = pc_q;
    assign inst_credit_o = credit_q;
    assign deq           = fq_valid_o && !stall_i; // head moves into decode

    // source only sends while holding a credit, so no full check
    always_ff @(posedge clk) begin
        if (inst_valid_i) begin
            fq_mem[wr_ptr] <= inst_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fq_cnt   <= '0;
            pc_q     <= '0;
            credit_q <= 1'b0;
        end else begin
            credit_q <= deq; // one credit back per dequeue
            if (inst_valid_i) begin
                wr_ptr <= wr_ptr + 1'b1; // depth is a power of two
            end
            if (deq) begin
                rd_ptr <= rd_ptr + 1'b1;
                pc_q   <= pc_q + `XLEN'd4; // no branches, pc only steps
            end
            case ({inst_valid_i, deq})
                2'b10:   fq_cnt <= fq_cnt + 1'b1;
                2'b01:   fq_cnt <= fq_cnt - 1'b1;
                default: fq_cnt <= fq_cnt;
            endcase
        end
    end

endmodule

// File: src/id_stage.sv
// instruction decode, register file with forwarding, id/ex register
`timescale 1ns/10ps
`include "rvseed_defines.svh"

module id_stage (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  stall_i,
    input  logic                  fq_valid_i,
    input  logic [31:0]           fq_inst_i,
    input  logic [`XLEN-1:0]      fq_pc_i,
    input  logic                  ex_fwd_wen_i,
    input  logic [`REG_AW-1:0]    ex_fwd_rd_i,
    input  logic [`XLEN-1:0]      ex_fwd_data_i,
    input  logic                  rf_wen_i,
    input  logic [`REG_AW-1:0]    rf_waddr_i,
    input  logic [`XLEN-1:0]      rf_wdata_i,
    output logic                  ex_valid_o,
    output rvseed_pkg::alu_op_e   ex_op_o,
    output logic [`XLEN-1:0]      ex_src1_o,
    output logic [`XLEN-1:0]      ex_src2_o,
    output logic [`REG_AW-1:0]    ex_rd_o,
    output logic                  ex_wen_o,
    output logic                  ex_unknown_o,
    output logic [`XLEN-1:0]      ex_pc_o
);
    import rvseed_pkg::*;

    rv_inst_u          inst_w;
    logic [`XLEN-1:0]  rf [`NREG];
    alu_op_e           op_d;
    logic              unknown_d;
    logic              use_imm;
    logic [`XLEN-1:0]  imm_ext;
    logic [`XLEN-1:0]  rs1_val;
    logic [`XLEN-1:0]  rs2_val;

    // execute beats write-back beats the file, x0 reads zero
    function automatic logic [`XLEN-1:0] fwd_read(
        input logic [`REG_AW-1:0] idx,
        input logic [`XLEN-1:0]   file_val,
        input logic               exw,
        input logic [`REG_AW-1:0] exrd,
        input logic [`XLEN-1:0]   exdata,
        input logic               wbw,
        input logic [`REG_AW-1:0] wbrd,
        input logic [`XLEN-1:0]   wbdata
    );
        if (idx == '0) begin
            return '0;
        end else if (exw && exrd == idx) begin
            return exdata;
        end else if (wbw && wbrd == idx) begin
            return wbdata;
        end
        return file_val;
    endfunction

    assign inst_w  = fq_inst_i;
    assign imm_ext = {{(`XLEN-12){inst_w.i_view.imm12[11]}}, inst_w.i_view.imm12};
    assign rs1_val = fwd_read(inst_w.r_view.rs1, rf[inst_w.r_view.rs1], ex_fwd_wen_i,
                              ex_fwd_rd_i, ex_fwd_data_i, rf_wen_i, rf_waddr_i, rf_wdata_i);
    assign rs2_val = fwd_read(inst_w.r_view.rs2, rf[inst_w.r_view.rs2], ex_fwd_wen_i,
                              ex_fwd_rd_i, ex_fwd_data_i, rf_wen_i, rf_waddr_i, rf_wdata_i);

    always_comb begin
        op_d      = ALU_NONE;
        unknown_d = 1'b1;
        use_imm   = 1'b0;
        if (inst_w.r_view.opcode == OPC_OP) begin
            if (inst_w.r_view.funct7 == 7'b0000000) begin
                unknown_d = 1'b0;
                case (inst_w.r_view.funct3)
                    3'b000:  op_d = ALU_ADD;
                    3'b001:  op_d = ALU_SLL;
                    3'b010:  op_d = ALU_SLT;
                    3'b100:  op_d = ALU_XOR;
                    3'b101:  op_d = ALU_SRL;
                    3'b110:  op_d = ALU_OR;
                    3'b111:  op_d = ALU_AND;
                    default: unknown_d = 1'b1; // sltu not supported
                endcase
            end else if (inst_w.r_view.funct7 == 7'b0100000 &&
                         inst_w.r_view.funct3 == 3'b000) begin
                op_d      = ALU_SUB;
                unknown_d = 1'b0;
            end
        end else if (inst_w.i_view.opcode == OPC_OP_IMM) begin
            unknown_d = 1'b0;
            use_imm   = 1'b1;
            case (inst_w.i_view.funct3)
                3'b000:  op_d = ALU_ADD;
                3'b100:  op_d = ALU_XOR;
                3'b110:  op_d = ALU_OR;
                3'b111:  op_d = ALU_AND;
                default: unknown_d = 1'b1; // slti and immediate shifts
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `NREG; i++) begin
                rf[i] <= '0;
            end
        end else if (rf_wen_i) begin
            rf[rf_waddr_i] <= rf_wdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ex_valid_o   <= 1'b0;
            ex_op_o      <= ALU_NONE;
            ex_wen_o     <= 1'b0;
            ex_unknown_o <= 1'b0;
        end else if (!stall_i) begin
            ex_valid_o   <= fq_valid_i;
            ex_op_o      <= op_d;
            ex_wen_o     <= fq_valid_i && !unknown_d;
            ex_unknown_o <= fq_valid_i && unknown_d;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            ex_src1_o <= rs1_val;
            ex_src2_o <= use_imm ? imm_ext : rs2_val;
            ex_rd_o   <= inst_w.r_view.rd;
            ex_pc_o   <= fq_pc_i;
        end
    end

endmodule

// File: src/ex_stage.sv
// 64-bit ALU, execute forwarding path and ex/wb register
`timescale 1ns/10ps
`include "rvseed_defines.svh"

module ex_stage (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  stall_i,
    input  logic                  ex_valid_i,
    input  rvseed_pkg::alu_op_e   ex_op_i,
    input  logic [`XLEN-1:0]      ex_src1_i,
    input  logic [`XLEN-1:0]      ex_src2_i,
    input  logic [`REG_AW-1:0]    ex_rd_i,
    input  logic                  ex_wen_i,
    input  logic                  ex_unknown_i,
    input  logic [`XLEN-1:0]      ex_pc_i,
    output logic                  ex_fwd_wen_o,
    output logic [`REG_AW-1:0]    ex_fwd_rd_o,
    output logic [`XLEN-1:0]      ex_fwd_data_o,
    output logic                  wb_valid_o,
    output logic [`REG_AW-1:0]    wb_rd_o,
    output logic                  wb_wen_o,
    output logic [`XLEN-1:0]      wb_result_o,
    output logic                  wb_unknown_o,
    output logic [`XLEN-1:0]      wb_pc_o
);
    import rvseed_pkg::*;

    logic [`XLEN-1:0] alu_res;
    logic             slt_bit;

    assign slt_bit = $signed(ex_src1_i) < $signed(ex_src2_i);

    always_comb begin
        case (ex_op_i)
            ALU_ADD: alu_res = ex_src1_i + ex_src2_i;
            ALU_SUB: alu_res = ex_src1_i - ex_src2_i;
            ALU_AND: alu_res = ex_src1_i & ex_src2_i;
            ALU_OR:  alu_res = ex_src1_i | ex_src2_i;
            ALU_XOR: alu_res = ex_src1_i ^ ex_src2_i;
            ALU_SLL: alu_res = ex_src1_i << ex_src2_i[5:0]; // rv64 shamt
            ALU_SRL: alu_res = ex_src1_i >> ex_src2_i[5:0];
            ALU_SLT: alu_res = {{(`XLEN-1){1'b0}}, slt_bit};
            default: alu_res = '0;
        endcase
    end

    // bypass to decode for the next instruction
    assign ex_fwd_wen_o  = ex_valid_i && ex_wen_i;
    assign ex_fwd_rd_o   = ex_rd_i;
    assign ex_fwd_data_o = alu_res;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_valid_o   <= 1'b0;
            wb_wen_o     <= 1'b0;
            wb_unknown_o <= 1'b0;
        end else if (!stall_i) begin
            wb_valid_o   <= ex_valid_i;
            wb_wen_o     <= ex_wen_i;
            wb_unknown_o <= ex_unknown_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            wb_rd_o     <= ex_rd_i;
            wb_result_o <= alu_res;
            wb_pc_o     <= ex_pc_i;
        end
    end

endmodule

// File: src/wb_stage.sv
// register write-back, retire port and retire-credit counter driving the stall
`timescale 1ns/10ps
`include "rvseed_defines.svh"

module wb_stage (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  wb_valid_i,
    input  logic [`REG_AW-1:0]    wb_rd_i,
    input  logic                  wb_wen_i,
    input  logic [`XLEN-1:0]      wb_result_i,
    input  logic                  wb_unknown_i,
    input  logic [`XLEN-1:0]      wb_pc_i,
    input  logic                  ret_credit_i,
    output logic                  stall_o,
    output logic                  rf_wen_o,
    output logic [`REG_AW-1:0]    rf_waddr_o,
    output logic [`XLEN-1:0]      rf_wdata_o,
    output logic                  ret_valid_o,
    output logic [`XLEN-1:0]      ret_pc_o,
    output logic [`REG_AW-1:0]    ret_rd_o,
    output logic [`XLEN-1:0]      ret_wdata_o,
    output logic                  ret_wen_o,
    output logic                  ret_unknown_o
);

    logic [`RET_CNT_W-1:0] credit_cnt;
    logic                  has_credit;
    logic                  retire;

    assign has_credit = (credit_cnt != '0);
    assign retire     = wb_valid_i && has_credit;
    assign stall_o    = wb_valid_i && !has_credit; // freezes the whole pipe

    assign ret_valid_o   = retire;
    assign ret_pc_o      = wb_pc_i;
    assign ret_rd_o      = wb_rd_i;
    assign ret_wdata_o   = wb_result_i;
    assign ret_wen_o     = wb_wen_i;
    assign ret_unknown_o = wb_unknown_i;

    // x0 stays zero, the retire port still shows the value
    assign rf_wen_o   = retire && wb_wen_i && (wb_rd_i != '0);
    assign rf_waddr_o = wb_rd_i;
    assign rf_wdata_o = wb_result_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            credit_cnt <= '0; // consumer grants credits after reset
        end else begin
            case ({ret_credit_i, retire})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt; // grant and spend cancel
            endcase
        end
    end

endmodule

// File: src/rvseed_top.sv
// core top level wiring fetch, decode, execute and write-back stages
`timescale 1ns/10ps
`include "rvseed_defines.svh"

module rvseed_top (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                inst_valid_i,
    input  logic [31:0]         inst_i,
    output logic                inst_credit_o,
    output logic                ret_valid_o,
    output logic [`XLEN-1:0]    ret_pc_o,
    output logic [`REG_AW-1:0]  ret_rd_o,
    output logic [`XLEN-1:0]    ret_wdata_o,
    output logic                ret_wen_o,
    output logic                ret_unknown_o,
    input  logic                ret_credit_i
);
    import rvseed_pkg::*;

    logic                stall;
    logic                fq_valid;
    logic [31:0]         fq_inst;
    logic [`XLEN-1:0]    fq_pc;
    logic                ex_valid;
    alu_op_e             ex_op;
    logic [`XLEN-1:0]    ex_src1;
    logic [`XLEN-1:0]    ex_src2;
    logic [`REG_AW-1:0]  ex_rd;
    logic                ex_wen;
    logic                ex_unknown;
    logic [`XLEN-1:0]    ex_pc;
    logic                ex_fwd_wen;
    logic [`REG_AW-1:0]  ex_fwd_rd;
    logic [`XLEN-1:0]    ex_fwd_data;
    logic                wb_valid;
    logic [`REG_AW-1:0]  wb_rd;
    logic                wb_wen;
    logic [`XLEN-1:0]    wb_result;
    logic                wb_unknown;
    logic [`XLEN-1:0]    wb_pc;
    logic                rf_wen;      // write-back port, also the second bypass
    logic [`REG_AW-1:0]  rf_waddr;
    logic [`XLEN-1:0]    rf_wdata;

    if_stage u_if_stage (
        .clk(clk), .rst_n_i(rst_n_i), .inst_valid_i(inst_valid_i), .inst_i(inst_i),
        .stall_i(stall), .inst_credit_o(inst_credit_o), .fq_valid_o(fq_valid),
        .fq_inst_o(fq_inst), .fq_pc_o(fq_pc)
    );

    id_stage u_id_stage (
        .clk(clk), .rst_n_i(rst_n_i), .stall_i(stall), .fq_valid_i(fq_valid),
        .fq_inst_i(fq_inst), .fq_pc_i(fq_pc), .ex_fwd_wen_i(ex_fwd_wen),
        .ex_fwd_rd_i(ex_fwd_rd), .ex_fwd_data_i(ex_fwd_data), .rf_wen_i(rf_wen),
        .rf_waddr_i(rf_waddr), .rf_wdata_i(rf_wdata), .ex_valid_o(ex_valid),
        .ex_op_o(ex_op), .ex_src1_o(ex_src1), .ex_src2_o(ex_src2), .ex_rd_o(ex_rd),
        .ex_wen_o(ex_wen), .ex_unknown_o(ex_unknown), .ex_pc_o(ex_pc)
    );

    ex_stage u_ex_stage (
        .clk(clk), .rst_n_i(rst_n_i), .stall_i(stall), .ex_valid_i(ex_valid),
        .ex_op_i(ex_op), .ex_src1_i(ex_src1), .ex_src2_i(ex_src2), .ex_rd_i(ex_rd),
        .ex_wen_i(ex_wen), .ex_unknown_i(ex_unknown), .ex_pc_i(ex_pc),
        .ex_fwd_wen_o(ex_fwd_wen), .ex_fwd_rd_o(ex_fwd_rd), .ex_fwd_data_o(ex_fwd_data),
        .wb_valid_o(wb_valid), .wb_rd_o(wb_rd), .wb_wen_o(wb_wen),
        .wb_result_o(wb_result), .wb_unknown_o(wb_unknown), .wb_pc_o(wb_pc)
    );

    wb_stage u_wb_stage (
        .clk(clk), .rst_n_i(rst_n_i), .wb_valid_i(wb_valid), .wb_rd_i(wb_rd),
        .wb_wen_i(wb_wen), .wb_result_i(wb_result), .wb_unknown_i(wb_unknown),
        .wb_pc_i(wb_pc), .ret_credit_i(ret_credit_i), .stall_o(stall),
        .rf_wen_o(rf_wen), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata),
        .ret_valid_o(ret_valid_o), .ret_pc_o(ret_pc_o), .ret_rd_o(ret_rd_o),
        .ret_wdata_o(ret_wdata_o), .ret_wen_o(ret_wen_o), .ret_unknown_o(ret_unknown_o)
    );

endmodule

// File: bench/tb_model.svh
// reference register-file model and expected-retire function for the core testbench
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

localparam logic [6:0] OPC_REG = 7'b0110011; // register-register major opcode
localparam logic [6:0] OPC_IMM = 7'b0010011; // register-immediate major opcode

logic [63:0] model_rf [32]; // architectural state after each retire

// expected retire fields for the idx-th word in program order
function automatic void expect_retire(
    input  logic [63:0] regs [32],
    input  logic [31:0] word,
    input  int          idx,
    output logic [63:0] pc,
    output logic [4:0]  rd,
    output logic [63:0] wdata,
    output logic        wen,
    output logic        unknown
);
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] imm;
    logic [2:0]  f3;
    a       = regs[word[19:15]];
    b       = regs[word[24:20]];
    imm     = {{52{word[31]}}, word[31:20]};
    f3      = word[14:12];
    pc      = 64'(idx) * 64'd4; // straight-line code only
    rd      = word[11:7];
    wdata   = '0;
    unknown = 1'b0;
    if (word[6:0] == OPC_REG && word[31:25] == 7'b0100000 && f3 == 3'b000) begin
        wdata = a - b;
    end else if (word[6:0] == OPC_REG && word[31:25] == 7'b0000000) begin
        case (f3)
            3'b000:  wdata = a + b;
            3'b001:  wdata = a << b[5:0];
            3'b010:  wdata = {63'd0, $signed(a) < $signed(b)};
            3'b100:  wdata = a ^ b;
            3'b101:  wdata = a >> b[5:0];
            3'b110:  wdata = a | b;
            3'b111:  wdata = a & b;
            default: unknown = 1'b1; // sltu
        endcase
    end else if (word[6:0] == OPC_IMM) begin
        case (f3)
            3'b000:  wdata = a + imm;
            3'b100:  wdata = a ^ imm;
            3'b110:  wdata = a | imm;
            3'b111:  wdata = a & imm;
            default: unknown = 1'b1; // slti, shifts by immediate
        endcase
    end else begin
        unknown = 1'b1;
    end
    wen = !unknown;
endfunction

`endif

// File: bench/tb_top.sv
// testbench for the core: clock, reset, credit-driven stimulus, retire checker, watchdog
`timescale 1ns/10ps
`include "rvseed_defines.svh"

module tb_top;

    localparam int N_IDLE      = 4;
    localparam int N_ALU       = 120; // 3 rounds of 8 ops, 5 words each
    localparam int N_DEP       = 18;
    localparam int N_X0        = 4;
    localparam int N_UNK       = 4;
    localparam int N_STARVE    = 30;
    localparam int TOTAL_INSTS = N_IDLE + N_ALU + N_DEP + N_X0 + N_UNK + N_STARVE;

    logic             clk          = 1'b0;
    logic             rst_n_i      = 1'b0;
    logic             inst_valid_i = 1'b0;
    logic [31:0]      inst_i       = '0;
    logic             ret_credit_i = 1'b0;
    logic             inst_credit_o;
    logic             ret_valid_o;
    logic [`XLEN-1:0] ret_pc_o;
    logic [4:0]       ret_rd_o;
    logic [`XLEN-1:0] ret_wdata_o;
    logic             ret_wen_o;
    logic             ret_unknown_o;

    logic [31:0] prog [TOTAL_INSTS];
    int prog_len     = 0; // words queued by the sequence
    int sent_cnt     = 0;
    int credits_back = 0; // inst_credit_o pulses seen
    int granted      = 0; // retire credits handed out
    int retired      = 0;
    int credit_pct   = 0; // retire credit chance per cycle
    int check_errs   = 0;
    int flow_errs    = 0;
    int checks       = 0;
    int tests        = 0;
    int test_start   = 0;

    `include "tb_model.svh"

    rvseed_top uut (
        .clk(clk), .rst_n_i(rst_n_i), .inst_valid_i(inst_valid_i), .inst_i(inst_i),
        .inst_credit_o(inst_credit_o), .ret_valid_o(ret_valid_o), .ret_pc_o(ret_pc_o),
        .ret_rd_o(ret_rd_o), .ret_wdata_o(ret_wdata_o), .ret_wen_o(ret_wen_o),
        .ret_unknown_o(ret_unknown_o), .ret_credit_i(ret_credit_i)
    );

    always #4 clk = ~clk;

    // sel 0..7 picks an R-type op, 8..11 an I-type op
    function automatic logic [31:0] op_word(input int sel, input logic [4:0] rd,
                                            input logic [4:0] rs1, input logic [4:0] rs2,
                                            input logic [11:0] imm);
        case (sel)
            0:       return {7'b0000000, rs2, rs1, 3'b000, rd, OPC_REG};
            1:       return {7'b0100000, rs2, rs1, 3'b000, rd, OPC_REG};
            2:       return {7'b0000000, rs2, rs1, 3'b111, rd, OPC_REG};
            3:       return {7'b0000000, rs2, rs1, 3'b110, rd, OPC_REG};
            4:       return {7'b0000000, rs2, rs1, 3'b100, rd, OPC_REG};
            5:       return {7'b0000000, rs2, rs1, 3'b001, rd, OPC_REG};
            6:       return {7'b0000000, rs2, rs1, 3'b101, rd, OPC_REG};
            7:       return {7'b0000000, rs2, rs1, 3'b010, rd, OPC_REG};
            8:       return {imm, rs1, 3'b000, rd, OPC_IMM};
            9:       return {imm, rs1, 3'b111, rd, OPC_IMM};
            10:      return {imm, rs1, 3'b110, rd, OPC_IMM};
            default: return {imm, rs1, 3'b100, rd, OPC_IMM};
        endcase
    endfunction

    function automatic logic [11:0] rand_imm();
        logic [31:0] r;
        r = $urandom;
        return r[11:0];
    endfunction

    task automatic push_word(input logic [31:0] w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    task automatic wait_retired();
        while (retired != prog_len) begin
            @(posedge clk);
        end
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = check_errs + flow_errs;
        $display("test %-7s done, %0d errors", name, errs - test_start);
        test_start = errs;
        tests++;
    endtask

    // source side, spends one instruction credit per word sent
    always @(posedge clk) begin
        if (!rst_n_i) begin
            inst_valid_i <= 1'b0;
            ret_credit_i <= 1'b0;
        end else begin
            if (sent_cnt < prog_len && sent_cnt < `FQ_DEPTH + credits_back) begin
                inst_valid_i <= 1'b1;
                inst_i       <= prog[sent_cnt];
                sent_cnt++;
            end else begin
                inst_valid_i <= 1'b0;
            end
            if (granted - retired < `RET_CREDIT_MAX && ($urandom % 100) < credit_pct) begin
                ret_credit_i <= 1'b1;
                granted++;
            end else begin
                ret_credit_i <= 1'b0;
            end
        end
    end

    // retire checker, outputs settle well before the falling edge
    always @(negedge clk) begin
        logic [63:0] e_pc;
        logic [63:0] e_wdata;
        logic [4:0]  e_rd;
        logic        e_wen;
        logic        e_unk;
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                model_rf[i] = '0;
            end
        end else begin
            if (inst_credit_o) begin
                credits_back++;
            end
            if (ret_valid_o) begin
                checks++;
                if (retired >= granted) begin
                    $display("retire at %0t used a credit that was never granted", $time);
                    check_errs++;
                end
                if (retired >= prog_len) begin
                    $display("retire at %0t with no instruction outstanding", $time);
                    check_errs++;
                end else begin
                    expect_retire(model_rf, prog[retired], retired,
                                  e_pc, e_rd, e_wdata, e_wen, e_unk);
                    if (ret_pc_o !== e_pc) begin
                        $display("FAILED ret_pc_o: got %h expected %h", ret_pc_o, e_pc);
                        check_errs++;
                    end
                    if (ret_unknown_o !== e_unk) begin
                        $display("FAILED ret_unknown_o at pc %h: got %h expected %h",
                                 e_pc, ret_unknown_o, e_unk);
                        check_errs++;
                    end
                    if (ret_wen_o !== e_wen) begin
                        $display("FAILED ret_wen_o at pc %h: got %h expected %h",
                                 e_pc, ret_wen_o, e_wen);
                        check_errs++;
                    end
                    if (!e_unk && ret_rd_o !== e_rd) begin
                        $display("FAILED ret_rd_o at pc %h: got %h expected %h",
                                 e_pc, ret_rd_o, e_rd);
                        check_errs++;
                    end
                    if (!e_unk && ret_wdata_o !== e_wdata) begin
                        $display("FAILED ret_wdata_o at pc %h: got %h expected %h",
                                 e_pc, ret_wdata_o, e_wdata);
                        check_errs++;
                    end
                    if (e_wen && e_rd != 5'd0) begin
                        model_rf[e_rd] = e_wdata; // x0 stays zero
                    end
                end
                retired++;
            end
        end
    end

    initial begin
        int          sel;
        logic [31:0] r;
        void'($urandom(32'heeb3));
        repeat (8) @(posedge clk);
        rst_n_i <= 1'b1;

        // words queue up but nothing may retire without credit
        for (int i = 0; i < N_IDLE; i++) begin
            push_word(op_word(8, 5'(i + 1), 5'd0, 5'd0, rand_imm()));
        end
        repeat (30) @(posedge clk);
        if (retired != 0) begin
            $display("an instruction retired before any retire credit was granted");
            flow_errs++;
        end
        credit_pct = 50;
        wait_retired();
        end_test("idle");

        for (int round = 0; round < 3; round++) begin
            for (int op = 0; op < 8; op++) begin
                push_word(op_word(8, 5'd1, 5'd0, 5'd0, rand_imm()));
                push_word(op_word(11, 5'd1, 5'd1, 5'd0, rand_imm()));
                push_word(op_word(8, 5'd2, 5'd0, 5'd0, rand_imm()));
                push_word(op_word(11, 5'd2, 5'd2, 5'd0, rand_imm()));
                push_word(op_word(op, 5'd5, 5'd1, 5'd2, 12'd0));
            end
        end
        wait_retired();
        end_test("alu");

        // rs1 from the word just before, rs2 from two words back
        push_word(op_word(8, 5'd7, 5'd0, 5'd0, rand_imm()));
        push_word(op_word(8, 5'd8, 5'd0, 5'd0, rand_imm()));
        for (int i = 0; i < 16; i++) begin
            sel = $urandom % 12;
            if (i % 2 == 0) begin
                push_word(op_word(sel, 5'd7, 5'd8, 5'd7, rand_imm()));
            end else begin
                push_word(op_word(sel, 5'd8, 5'd7, 5'd8, rand_imm()));
            end
        end
        wait_retired();
        end_test("forward");

        push_word(op_word(8, 5'd0, 5'd0, 5'd0, rand_imm() | 12'h001)); // nonzero into x0
        push_word(op_word(0, 5'd9, 5'd0, 5'd0, 12'd0));
        push_word(op_word(8, 5'd3, 5'd0, 5'd0, rand_imm()));
        push_word(op_word(4, 5'd10, 5'd0, 5'd3, 12'd0));
        wait_retired();
        end_test("x0");

        push_word(op_word(8, 5'd11, 5'd0, 5'd0, rand_imm()));
        push_word({12'h000, 5'd0, 3'b011, 5'd11, 7'b0000011});        // load
        push_word({7'b0000000, 5'd2, 5'd1, 3'b011, 5'd11, OPC_REG}); // sltu
        push_word(op_word(0, 5'd12, 5'd11, 5'd0, 12'd0));            // x11 must be intact
        wait_retired();
        end_test("unknown");

        credit_pct = 10; // starve the retire port
        for (int i = 0; i < N_STARVE; i++) begin
            r   = $urandom;
            sel = $urandom % 12;
            push_word(op_word(sel, 5'(1 + r % 15), {1'b0, r[19:16]}, {1'b0, r[23:20]},
                              r[31:20]));
        end
        wait_retired();
        repeat (2) @(posedge clk);
        if (credits_back != prog_len || sent_cnt != prog_len) begin
            $display("inst_credit_o pulsed %0d times for %0d words sent of %0d",
                     credits_back, sent_cnt, prog_len);
            flow_errs++;
        end
        end_test("starve");

        $display("%0d tests, %0d retire checks, %0d errors", tests, checks,
                 check_errs + flow_errs);
        if (check_errs + flow_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (TOTAL_INSTS * 40) @(posedge clk);
        $display("watchdog expired with %0d of %0d instructions retired", retired, prog_len);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: build.f
+incdir+src
+incdir+bench
src/rvseed_pkg.sv
src/if_stage.sv
src/id_stage.sv
src/ex_stage.sv
src/wb_stage.sv
src/rvseed_top.sv
bench/tb_top.sv

// File: run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps -f build.f --top-module tb_top -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^RESULT: PASS$"; then
    exit 0
fi
exit 1
